/* verilog/cacheStorePkg.sv */
// Storage-side types for the data cache
// Word type, address field widths and the stored frame layout

`default_nettype none

package cacheStorePkg;

	// Data word and byte address share one width
	typedef logic [31:0] word_t;

	// Address fields below the index
	localparam int byteOffBits  = 2;
	localparam int blockOffBits = 1;

	// One two-word block as held in a way
	typedef struct packed {
		// Full byte address of wordA, offsets are zero
		word_t blockAddr;
		word_t wordA;
		word_t wordB;
		logic  valid;
		logic  dirty;
	} frame_t;

endpackage

`default_nettype wire

/* verilog/cacheBusPkg.sv */
// Bus and control types for the data cache
// Processor and memory bus structs, storage commands,
// lookup result and controller states

`default_nettype none

package cacheBusPkg;
	import cacheStorePkg::*;

	// Load/store port from the processor
	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
		logic  halt;
	} cpuReq_t;

	typedef struct packed {
		logic  dhit;
		word_t load;
		logic  flushed;
	} cpuResp_t;

	// Word-wide memory bus
	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} memReq_t;

	typedef struct packed {
		word_t load;
		// Memory stalls the access while high
		logic  busWait;
	} memResp_t;

	// What the lookup found in the selected set
	typedef struct packed {
		logic   hit;
		logic   hitWay;
		logic   victimWay;
		logic   victimDirty;
		frame_t victim;
		word_t  word;
		logic   anyDirty;
	} lookup_t;

	// Fill order, one word per memory read
	typedef struct packed {
		logic  en;
		logic  sel;
		logic  finish;
		word_t blockAddr;
	} fillCmd_t;

	typedef struct packed {
		logic     way;
		fillCmd_t fill;
		logic     write;
		logic     clean;
		logic     touch;
	} storeCmd_t;

	typedef enum logic [3:0] {
		Idle,
		ReadHit,
		Overwrite,
		WriteHit,
		CleanA,
		CleanB,
		FillA,
		FillB,
		Flush,
		Stop
	} ctrlState_t;

endpackage

`default_nettype wire

/* verilog/cacheStorage.sv */
// Way storage for the data cache
// Two frame arrays with valid and dirty bits, one recently-used bit per set,
// and the fill, write, clean and touch update rules

`timescale 1ns/10ps
`default_nettype none

module cacheStorage
	import cacheStorePkg::*, cacheBusPkg::*;
#(
	parameter int numSets = 8
) (
	input  logic                       CLK,
	input  logic                       nRST,
	input  logic [$clog2(numSets)-1:0] lookupIdx,
	input  storeCmd_t                  cmd,
	input  word_t                      store,
	input  word_t                      memLoad,
	input  word_t                      reqAddr,
	output frame_t                     way0,
	output frame_t                     way1,
	output logic [2*numSets-1:0]       dirtyMap,
	output logic                       lruWay
);

	// Indexed by way, then by set
	frame_t frames [2][numSets];

	// Way touched last in each set
	logic [numSets-1:0] recUsed;

	logic wordSel;

	// Block offset bit picks the word a store lands in
	assign wordSel = reqAddr[byteOffBits];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			frames <= '{default: '0};
		end else begin
			if (cmd.fill.en) begin
				if (cmd.fill.sel) begin
					frames[cmd.way][lookupIdx].wordB <= memLoad;
				end else begin
					frames[cmd.way][lookupIdx].wordA <= memLoad;
				end
				frames[cmd.way][lookupIdx].dirty <= 1'b0;

				// Block only becomes valid once both words are in
				if (cmd.fill.finish) begin
					frames[cmd.way][lookupIdx].blockAddr <= cmd.fill.blockAddr;
					frames[cmd.way][lookupIdx].valid     <= 1'b1;
				end
			end

			// Store merge on a hit frame
			if (cmd.write) begin
				if (wordSel) begin
					frames[cmd.way][lookupIdx].wordB <= store;
				end else begin
					frames[cmd.way][lookupIdx].wordA <= store;
				end
				frames[cmd.way][lookupIdx].dirty <= 1'b1;
			end

			if (cmd.clean) begin
				frames[cmd.way][lookupIdx].dirty <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			recUsed <= '0;
		end else if (cmd.touch) begin
			recUsed[lookupIdx] <= cmd.way;
		end
	end

	assign way0   = frames[0][lookupIdx];
	assign way1   = frames[1][lookupIdx];
	assign lruWay = ~recUsed[lookupIdx];

	// Way 0 sets in the low half, way 1 sets above
	always_comb begin
		for (int s = 0; s < numSets; s++) begin
			dirtyMap[s]           = frames[0][s].dirty;
			dirtyMap[numSets + s] = frames[1][s].dirty;
		end
	end

endmodule

`default_nettype wire

/* verilog/hitLookup.sv */
// Hit lookup for the data cache
// Index selection, tag compare, word select, victim choice
// and the dirty-frame scan used while flushing

`timescale 1ns/10ps
`default_nettype none

module hitLookup
	import cacheStorePkg::*, cacheBusPkg::*;
#(
	parameter int numSets = 8
) (
	input  cpuReq_t                    cpuReq,
	input  frame_t                     way0,
	input  frame_t                     way1,
	input  logic [2*numSets-1:0]       dirtyMap,
	input  logic                       lruWay,
	output logic [$clog2(numSets)-1:0] lookupIdx,
	output lookup_t                    result
);

	localparam int idxBits = $clog2(numSets);
	localparam int offBits = byteOffBits + blockOffBits;
	localparam int tagLo   = offBits + idxBits;

	typedef logic [idxBits-1:0]               index_t;
	typedef logic [$bits(word_t)-1:tagLo]     tag_t;

	index_t reqIdx, flushIdx;
	tag_t   reqTag;
	logic   hit0, hit1, flushWay, victimWay;
	frame_t hitFrame;

	assign reqIdx = cpuReq.addr[offBits +: idxBits];
	assign reqTag = cpuReq.addr[$bits(word_t)-1:tagLo];

	assign hit0 = way0.valid && (way0.blockAddr[$bits(word_t)-1:tagLo] == reqTag);
	assign hit1 = way1.valid && (way1.blockAddr[$bits(word_t)-1:tagLo] == reqTag);

	// First dirty frame, way 0 in index order before way 1
	always_comb begin
		flushIdx = '0;
		flushWay = 1'b0;
		for (int i = 2*numSets - 1; i >= 0; i--) begin
			if (dirtyMap[i]) begin
				flushIdx = index_t'(i % numSets);
				flushWay = (i >= numSets);
			end
		end
	end

	assign lookupIdx = cpuReq.halt ? flushIdx : reqIdx;

	// Free ways first, then the older one
	always_comb begin
		if (cpuReq.halt) begin
			victimWay = flushWay;
		end else if (!way0.valid) begin
			victimWay = 1'b0;
		end else if (!way1.valid) begin
			victimWay = 1'b1;
		end else begin
			victimWay = lruWay;
		end
	end

	assign hitFrame = hit0 ? way0 : way1;

	always_comb begin
		result.hit         = hit0 | hit1;
		result.hitWay      = ~hit0;
		result.victimWay   = victimWay;
		result.victim      = victimWay ? way1 : way0;
		result.victimDirty = result.victim.dirty;
		result.word        = cpuReq.addr[byteOffBits] ? hitFrame.wordB : hitFrame.wordA;
		result.anyDirty    = |dirtyMap;
	end

endmodule

`default_nettype wire

/* verilog/missController.sv */
// Miss controller for the data cache
// State machine for hits, victim write-back, block fill and flush,
// driving the processor response, the memory bus and storage orders

`timescale 1ns/10ps
`default_nettype none

module missController
	import cacheStorePkg::*, cacheBusPkg::*;
(
	input  logic      CLK,
	input  logic      nRST,
	input  cpuReq_t   cpuReq,
	input  lookup_t   result,
	input  memResp_t  memResp,
	output storeCmd_t cmd,
	output cpuResp_t  cpuResp,
	output memReq_t   memReq
);

	localparam int    offBits  = byteOffBits + blockOffBits;
	localparam word_t wordStep = word_t'(1 << byteOffBits);

	ctrlState_t state, nextState;
	word_t      blockBase;
	logic       busWait;

	assign busWait   = memResp.busWait;
	assign blockBase = {cpuReq.addr[$bits(word_t)-1:offBits], {offBits{1'b0}}};

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= Idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (cpuReq.halt) begin
					nextState = Flush;
				end else if (cpuReq.ren || cpuReq.wen) begin
					if (result.hit) begin
						nextState = cpuReq.wen ? Overwrite : ReadHit;
					end else if (result.victimDirty) begin
						nextState = CleanA;
					end else begin
						nextState = FillA;
					end
				end
			end
			ReadHit:   nextState = Idle;
			Overwrite: nextState = WriteHit;
			WriteHit:  nextState = Idle;
			CleanA: if (!busWait) nextState = CleanB;
			CleanB: begin
				// Flush write-backs return to the scan
				if (!busWait) begin
					nextState = cpuReq.halt ? Flush : FillA;
				end
			end
			FillA: if (!busWait) nextState = FillB;
			FillB: begin
				if (!busWait) begin
					nextState = cpuReq.wen ? Overwrite : ReadHit;
				end
			end
			Flush:   nextState = result.anyDirty ? CleanA : Stop;
			Stop:    nextState = Stop;
			default: nextState = Idle;
		endcase
	end

	// Storage orders
	always_comb begin
		cmd                = '0;
		cmd.way            = result.victimWay;
		cmd.fill.blockAddr = blockBase;
		case (state)
			ReadHit: begin
				cmd.way   = result.hitWay;
				cmd.touch = 1'b1;
			end
			Overwrite: begin
				cmd.way   = result.hitWay;
				cmd.write = 1'b1;
			end
			WriteHit: begin
				cmd.way   = result.hitWay;
				cmd.touch = 1'b1;
			end
			// Dirty bit drops only after both words are out, so the flush scan holds still
			CleanB: cmd.clean = !busWait;
			FillA:  cmd.fill.en = !busWait;
			FillB: begin
				cmd.fill.en     = !busWait;
				cmd.fill.sel    = 1'b1;
				cmd.fill.finish = !busWait;
			end
			default: ;
		endcase
	end

	// Processor response
	always_comb begin
		cpuResp         = '0;
		cpuResp.dhit    = (state == ReadHit) || (state == WriteHit);
		cpuResp.load    = (state == ReadHit) ? result.word : '0;
		cpuResp.flushed = (state == Stop);
	end

	// Memory bus
	always_comb begin
		memReq = '0;
		case (state)
			CleanA: begin
				memReq.wen   = 1'b1;
				memReq.addr  = result.victim.blockAddr;
				memReq.store = result.victim.wordA;
			end
			CleanB: begin
				memReq.wen   = 1'b1;
				memReq.addr  = result.victim.blockAddr + wordStep;
				memReq.store = result.victim.wordB;
			end
			FillA: begin
				memReq.ren  = 1'b1;
				memReq.addr = blockBase;
			end
			FillB: begin
				memReq.ren  = 1'b1;
				memReq.addr = blockBase + wordStep;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/dataCache.sv */
// Two-way set-associative write-back data cache, top level
// Connects the lookup, the miss controller and the way storage

`timescale 1ns/10ps
`default_nettype none

module dataCache
	import cacheStorePkg::*, cacheBusPkg::*;
#(
	parameter int numSets = 8
) (
	input  logic     CLK,
	input  logic     nRST,
	input  cpuReq_t  cpuReq,
	output cpuResp_t cpuResp,
	output memReq_t  memReq,
	input  memResp_t memResp
);

	logic [$clog2(numSets)-1:0] lookupIdx;
	logic [2*numSets-1:0]       dirtyMap;
	frame_t                     way0, way1;
	logic                       lruWay;
	lookup_t                    result;
	storeCmd_t                  cmd;

	hitLookup #(.numSets(numSets)) lookup (
		.cpuReq   (cpuReq),
		.way0     (way0),
		.way1     (way1),
		.dirtyMap (dirtyMap),
		.lruWay   (lruWay),
		.lookupIdx(lookupIdx),
		.result   (result)
	);

	missController control (
		.CLK    (CLK),
		.nRST   (nRST),
		.cpuReq (cpuReq),
		.result (result),
		.memResp(memResp),
		.cmd    (cmd),
		.cpuResp(cpuResp),
		.memReq (memReq)
	);

	// Store data from the processor, fill data from memory
	cacheStorage #(.numSets(numSets)) storage (
		.CLK      (CLK),
		.nRST     (nRST),
		.lookupIdx(lookupIdx),
		.cmd      (cmd),
		.store    (cpuReq.store),
		.memLoad  (memResp.load),
		.reqAddr  (cpuReq.addr),
		.way0     (way0),
		.way1     (way1),
		.dirtyMap (dirtyMap),
		.lruWay   (lruWay)
	);

endmodule

`default_nettype wire

/* tb/cacheChecker.sv */
// Scoreboard for the data cache testbench
// Reference memory model, load, write-back and flush checks,
// and one report line per test

`timescale 1ns/10ps
`default_nettype none

module cacheChecker
	import cacheStorePkg::*, cacheBusPkg::*;
(
	input  logic     CLK,
	input  logic     nRST,
	input  cpuReq_t  cpuReq,
	input  cpuResp_t cpuResp,
	input  memReq_t  memReq,
	input  memResp_t memResp,
	input  logic     endRun,
	output logic     finished,
	output int       checks,
	output int       errors
);

	localparam int offBits = byteOffBits + blockOffBits;

	typedef enum {ResetPhase, TrafficPhase, FlushPhase, DonePhase} phase_t;

	// Processor view of memory, and memory as rebuilt from bus writes
	word_t  model [64];
	word_t  busMem [64];
	logic   used [64];
	phase_t phase;
	int     latency, testChecks, testErrors;
	logic   reqActive, lastValid, expectHit, curWrite, flushedSeen;
	word_t  curAddr, curStore, lastAddr;

	function automatic word_t patternWord(input word_t addr);
		return (addr * 32'h9E37_79B1) ^ 32'h5A0F_C3A5;
	endfunction

	function automatic int wordIdx(input word_t addr);
		return int'(addr[7:2]);
	endfunction

	task automatic expectHex(input string name, input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
		end
	endtask

	task automatic reportFault(input string what);
		errors++;
		$display("ERROR %s", what);
	endtask

	task automatic closeTest(input string name);
		$display("%s test done: %0d checks, %0d errors", name,
			checks - testChecks, errors - testErrors);
		testChecks = checks;
		testErrors = errors;
	endtask

	// Write-backs must carry the newest processor data
	task automatic watchMemWrite();
		if (memReq.wen && !memResp.busWait) begin
			expectHex("memStore", model[wordIdx(memReq.addr)], memReq.store);
			busMem[wordIdx(memReq.addr)] = memReq.store;
		end
	endtask

	task automatic completeRequest();
		if (expectHit) begin
			checks++;
			if (latency != (curWrite ? 2 : 1)) begin
				reportFault($sformatf("%s hit at 0x%h took %0d cycles instead of %0d",
					curWrite ? "write" : "read", curAddr, latency, curWrite ? 2 : 1));
			end
		end
		if (curWrite) begin
			model[wordIdx(curAddr)] = curStore;
		end else begin
			expectHex("dmemLoad", model[wordIdx(curAddr)], cpuResp.load);
		end
		lastAddr  = curAddr;
		lastValid = 1'b1;
		reqActive = 1'b0;
	endtask

	task automatic trackRequest();
		if (!reqActive && (cpuReq.ren || cpuReq.wen)) begin
			reqActive = 1'b1;
			curAddr   = cpuReq.addr;
			curWrite  = cpuReq.wen;
			curStore  = cpuReq.store;
			latency   = 0;
			// Block of the previous request is still resident
			expectHit = lastValid && ((cpuReq.addr >> offBits) == (lastAddr >> offBits));
			used[wordIdx(cpuReq.addr)] = 1'b1;
		end else if (reqActive) begin
			latency++;
		end
		if (cpuResp.dhit && !reqActive) begin
			reportFault("dhit pulsed with no request pending");
		end else if (cpuResp.dhit) begin
			completeRequest();
		end
	endtask

	task automatic flushStep();
		watchMemWrite();
		if (memReq.ren) begin
			reportFault("memory read issued while flushing");
		end
		if (cpuResp.dhit) begin
			reportFault("dhit pulsed while flushing");
		end
		if (flushedSeen) begin
			expectHex("flushed", 32'd1, word_t'(cpuResp.flushed));
			expectHex("memWen", '0, word_t'(memReq.wen));
		end else if (cpuResp.flushed) begin
			flushedSeen = 1'b1;
		end
		if (endRun) begin
			for (int i = 0; i < 64; i++) begin
				if (used[i]) begin
					expectHex($sformatf("memWord[0x%h]", i * 4), model[i], busMem[i]);
				end
			end
			closeTest("flush");
			phase    = DonePhase;
			finished = 1'b1;
		end
	endtask

	initial begin
		phase       = ResetPhase;
		checks      = 0;
		errors      = 0;
		testChecks  = 0;
		testErrors  = 0;
		latency     = 0;
		finished    = 1'b0;
		reqActive   = 1'b0;
		lastValid   = 1'b0;
		expectHit   = 1'b0;
		flushedSeen = 1'b0;
		for (int i = 0; i < 64; i++) begin
			model[i]  = patternWord(word_t'(i) << 2);
			busMem[i] = model[i];
			used[i]   = 1'b0;
		end
	end

	// Outputs are settled at the falling edge
	always @(negedge CLK) begin
		if (nRST) begin
			if (phase == ResetPhase) begin
				if (cpuReq.ren || cpuReq.wen || cpuReq.halt) begin
					closeTest("reset");
					phase = TrafficPhase;
				end else begin
					expectHex("dhit", '0, word_t'(cpuResp.dhit));
					expectHex("flushed", '0, word_t'(cpuResp.flushed));
					expectHex("memRen", '0, word_t'(memReq.ren));
					expectHex("memWen", '0, word_t'(memReq.wen));
				end
			end
			if (phase == TrafficPhase) begin
				watchMemWrite();
				trackRequest();
				if (cpuReq.halt && !reqActive) begin
					closeTest("traffic");
					phase = FlushPhase;
				end
			end else if (phase == FlushPhase) begin
				flushStep();
			end
		end
	end

endmodule

`default_nettype wire

/* tb/dataCacheTb.sv */
// Testbench top for the data cache
// Clock and reset, LFSR-driven load/store traffic, memory responder
// with random wait cycles, and the run watchdog

`timescale 1ns/10ps
`default_nettype none

module dataCacheTb
	import cacheStorePkg::*, cacheBusPkg::*;
();

	localparam int numSets  = 8;
	localparam int numReqs  = 200;
	localparam int memWords = 64;
	localparam int idxShift = byteOffBits + blockOffBits;
	localparam int tagShift = idxShift + $clog2(numSets);
	// Every frame dirty, two writes each with up to three waits
	localparam int flushCycles = 2 * numSets * 2 * 4 + 20;
	localparam int limitCycles = 16 + numReqs * 20 + flushCycles + 40;

	logic        CLK;
	logic        nRST;
	cpuReq_t     cpuReq;
	cpuResp_t    cpuResp;
	memReq_t     memReq;
	memResp_t    memResp;
	logic        endRun;
	logic        finished;
	int          checks;
	int          errors;
	logic [31:0] stimLfsr;
	logic [31:0] memLfsr;
	word_t       mem [memWords];
	word_t       lastAddr;
	logic        haveLast;

	dataCache #(.numSets(numSets)) DUT (
		.CLK    (CLK),
		.nRST   (nRST),
		.cpuReq (cpuReq),
		.cpuResp(cpuResp),
		.memReq (memReq),
		.memResp(memResp)
	);

	cacheChecker check (
		.CLK     (CLK),
		.nRST    (nRST),
		.cpuReq  (cpuReq),
		.cpuResp (cpuResp),
		.memReq  (memReq),
		.memResp (memResp),
		.endRun  (endRun),
		.finished(finished),
		.checks  (checks),
		.errors  (errors)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// Right-shifting Galois LFSR with maximal-length taps
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic drawBits(inout logic [31:0] state, input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], state[0]};
			state = lfsrNext(state);
		end
	endtask

	// Initial memory contents, mixed from the full address
	function automatic word_t patternWord(input word_t addr);
		return (addr * 32'h9E37_79B1) ^ 32'h5A0F_C3A5;
	endfunction

	// Tags 1 to 3 on sets 2 and 5, so blocks conflict and get evicted
	function automatic word_t poolAddr(input logic [1:0] tagSel, input logic idxSel, input logic off);
		word_t tag;
		word_t idx;
		tag = word_t'(tagSel % 3 + 1);
		idx = idxSel ? 32'd5 : 32'd2;
		return (tag << tagShift) | (idx << idxShift) | (word_t'(off) << byteOffBits);
	endfunction

	task automatic issueRequest();
		logic [31:0] op;
		logic [31:0] sel;
		logic [31:0] value;
		word_t       addr;
		drawBits(stimLfsr, 2, op);
		// Op 2 repeats the last address as a read
		if (op == 2 && haveLast) begin
			addr = lastAddr;
		end else begin
			drawBits(stimLfsr, 4, sel);
			addr = poolAddr(sel[3:2], sel[1], sel[0]);
		end
		cpuReq.addr = addr;
		if (op == 0) begin
			drawBits(stimLfsr, 32, value);
			cpuReq.ren   = 1'b0;
			cpuReq.wen   = 1'b1;
			cpuReq.store = value;
		end else begin
			cpuReq.ren   = 1'b1;
			cpuReq.wen   = 1'b0;
			cpuReq.store = '0;
		end
		lastAddr = addr;
		haveLast = 1'b1;
	endtask

	// Next request goes out in the idle cycle after dhit
	task automatic awaitHit();
		do @(negedge CLK); while (!cpuResp.dhit);
		@(posedge CLK);
		#5;
	endtask

	initial begin : responder
		int          waitLeft;
		logic        busy;
		logic [31:0] w;
		waitLeft = 0;
		busy     = 1'b0;
		memLfsr  = 32'd25;
		memResp  = '0;
		for (int i = 0; i < memWords; i++) begin
			mem[i] = patternWord(word_t'(i) << 2);
		end
		forever begin
			@(posedge CLK);
			#5;
			if (!nRST || !(memReq.ren || memReq.wen)) begin
				memResp.busWait = 1'b0;
				busy            = 1'b0;
			end else begin
				if (!busy) begin
					drawBits(memLfsr, 2, w);
					waitLeft = int'(w);
					busy     = 1'b1;
				end
				if (waitLeft > 0) begin
					memResp.busWait = 1'b1;
					waitLeft--;
				end else begin
					memResp.busWait = 1'b0;
					memResp.load    = mem[memReq.addr[7:2]];
					if (memReq.wen) begin
						mem[memReq.addr[7:2]] = memReq.store;
					end
					busy = 1'b0;
				end
			end
		end
	end

	initial begin
		repeat (limitCycles) @(posedge CLK);
		$display("Timeout: run not complete after %0d cycles", limitCycles);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		cpuReq   = '0;
		nRST     = 1'b0;
		endRun   = 1'b0;
		stimLfsr = 32'd25;
		lastAddr = '0;
		haveLast = 1'b0;
		repeat (16) @(posedge CLK);
		#5;
		nRST = 1'b1;
		// Quiet cycles for the reset checks
		repeat (3) @(posedge CLK);
		#5;
		for (int n = 0; n < numReqs; n++) begin
			issueRequest();
			awaitHit();
		end
		cpuReq      = '0;
		cpuReq.halt = 1'b1;
		do @(negedge CLK); while (!cpuResp.flushed);
		// Bus must stay quiet after the flush
		repeat (8) @(posedge CLK);
		#5;
		endRun = 1'b1;
		wait (finished);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/cacheStorePkg.sv
verilog/cacheBusPkg.sv
verilog/cacheStorage.sv
verilog/hitLookup.sv
verilog/missController.sv
verilog/dataCache.sv
tb/cacheChecker.sv
tb/dataCacheTb.sv

/* Bender.yml */
package:
  name: dataCache

sources:
  - verilog/cacheStorePkg.sv
  - verilog/cacheBusPkg.sv
  - verilog/cacheStorage.sv
  - verilog/hitLookup.sv
  - verilog/missController.sv
  - verilog/dataCache.sv
  - target: test
    files:
      - tb/cacheChecker.sv
      - tb/dataCacheTb.sv
